// File: filelist.f
+incdir+source
source/mem_issue_pkg.sv
source/iq_slot_if.sv
source/prf_busy_table.sv
source/issue_slot_mem.sv
source/iq_mem_allocator.sv
source/iq_mem_selector.sv
source/issue_queue_mem.sv
testbench/tb_issue_queue_mem.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the memory issue queue testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f \
  --top-module tb_issue_queue_mem -Mdir obj_dir -o sim_tb
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "Verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/sim_tb
sim_status=$?
if [ $sim_status -ne 0 ]; then
  echo "Simulation failed with status $sim_status"
  exit 1
fi

exit 0

// File: testbench/tb_issue_queue_mem.sv
//##########################################################
// Memory issue queue testbench
// Random dispatch, writeback and back-pressure stimulus
// checked against an ordered queue and busy-vector model
//##########################################################

`timescale 1ns/1ps
`default_nettype none

`include "mem_issue_defines.svh"

module tb_issue_queue_mem;
  import mem_issue_pkg::*;

  localparam int PRF_SIZE        = 1 << `PRF_INDEX_SIZE;
  localparam int REG_W           = `PRF_INDEX_SIZE;
  localparam int TAG_W           = `ROB_TAG_SIZE;
  localparam int RANDOM_CYCLES   = 600;
  localparam int DIRECTED_CYCLES = 16;
  localparam int DRAIN_TIMEOUT   = 400;

  logic                                  clock;
  logic                                  reset;
  micro_op_t [`DISPATCH_WIDTH-1:0]       dispatch_uop;
  logic                                  ex_busy;
  logic                                  wb_valid;
  logic [REG_W-1:0]                      wb_index;
  logic                                  dispatch_ready;
  micro_op_t                             issue_uop;
  logic                                  issue_valid;

  // Model state
  micro_op_t           model_q [$];
  logic [PRF_SIZE-1:0] model_busy;
  bit                  exp_ready;
  bit                  exp_fire;
  int                  pick_idx;
  int                  seed;
  int                  next_tag;
  int                  dispatched_count;
  int                  issued_count;
  int                  waited;

  issue_queue_mem DUT (
    .clock          (clock),
    .reset          (reset),
    .dispatch_uop   (dispatch_uop),
    .ex_busy        (ex_busy),
    .wb_valid       (wb_valid),
    .wb_index       (wb_index),
    .dispatch_ready (dispatch_ready),
    .issue_uop      (issue_uop),
    .issue_valid    (issue_valid)
  );

  always #4 clock = ~clock;

  task automatic fail_run();
    $display("Regression failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
      fail_run();
    end
  endtask

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return (r & 32'h7fff_ffff) % n;
  endfunction

  // Random register with the wanted busy state, -1 when none exists
  function automatic int find_reg(input bit want_busy, input int skip);
    int start;
    int r;
    start = rand_below(PRF_SIZE);
    for (int i = 0; i < PRF_SIZE; i++) begin
      r = (start + i) % PRF_SIZE;
      if (model_busy[r] == want_busy && r != skip) begin
        return r;
      end
    end
    return -1;
  endfunction

  function automatic bit op_ready(input micro_op_t u);
    bit rs1_ok;
    bit rs2_ok;
    rs1_ok = (u.rs1_source == RS_FROM_IMM) || !model_busy[u.rs1_index];
    rs2_ok = (u.rs2_source == RS_FROM_IMM) || !model_busy[u.rs2_index];
    return rs1_ok && rs2_ok;
  endfunction

  function automatic micro_op_t make_uop(input bit directed, input int skip_rd);
    micro_op_t u;
    int        rd;
    u            = '0;
    u.valid      = 1'b1;
    u.tag        = TAG_W'(next_tag);
    u.mem_type   = (rand_below(2) == 0) ? MEM_LD : MEM_ST;
    u.rs1_source = (directed || rand_below(3) == 0) ? RS_FROM_IMM : RS_FROM_RF;
    u.rs2_source = (directed || rand_below(3) == 0) ? RS_FROM_IMM : RS_FROM_RF;
    u.rs1_index  = REG_W'(rand_below(PRF_SIZE));
    u.rs2_index  = REG_W'(rand_below(PRF_SIZE));
    if (u.mem_type == MEM_LD) begin
      rd = find_reg(1'b0, skip_rd);
      // No idle register left, so send a store instead
      if (rd < 0) begin
        u.mem_type = MEM_ST;
      end else begin
        u.rd_index = REG_W'(rd);
      end
    end
    return u;
  endfunction

  // Mid-cycle check of the outputs against the model pick
  task automatic check_outputs();
    @(negedge clock);
    exp_ready = (`IQ_MEM_SIZE - model_q.size()) >= `DISPATCH_WIDTH;
    pick_idx  = -1;
    for (int i = 0; i < model_q.size(); i++) begin
      if (pick_idx < 0 && op_ready(model_q[i]) &&
          (model_q[i].mem_type == MEM_LD || i == 0)) begin
        pick_idx = i;
      end
    end
    exp_fire = (pick_idx >= 0) && !ex_busy;
    if (issue_valid) begin
      issued_count++;
    end
    check_value("dispatch_ready", 64'(dispatch_ready), 64'(exp_ready));
    check_value("issue_valid", 64'(issue_valid), 64'(exp_fire));
    if (exp_fire) begin
      check_value("issue_uop", 64'(issue_uop), 64'(model_q[pick_idx]));
    end
  endtask

  // Apply the edge to the model, then drive the next inputs
  task automatic advance_edge(input bit drain, input bit directed);
    micro_op_t [`DISPATCH_WIDTH-1:0] next_uop;
    logic [PRF_SIZE-1:0]             next_busy;
    bit                              held;
    int                              lanes;
    int                              skip;
    int                              r;
    @(posedge clock);
    if (exp_fire) begin
      model_q.delete(pick_idx);
    end
    next_busy = model_busy;
    if (wb_valid) begin
      next_busy[wb_index] = 1'b0;
    end
    held = 1'b0;
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      if (dispatch_uop[i].valid && exp_ready) begin
        model_q.push_back(dispatch_uop[i]);
        dispatched_count++;
        if (dispatch_uop[i].mem_type == MEM_LD) begin
          next_busy[dispatch_uop[i].rd_index] = 1'b1;
        end
      end else if (dispatch_uop[i].valid) begin
        held = 1'b1;
      end
    end
    model_busy = next_busy;

    // A refused group is held until the queue takes it
    next_uop = dispatch_uop;
    if (drain) begin
      next_uop = '0;
    end else if (!held) begin
      next_uop = '0;
      lanes    = rand_below(`DISPATCH_WIDTH + 1);
      skip     = -1;
      for (int i = 0; i < lanes; i++) begin
        next_uop[i] = make_uop(directed, skip);
        next_tag++;
        if (next_uop[i].mem_type == MEM_LD) begin
          skip = int'(next_uop[i].rd_index);
        end
      end
    end
    dispatch_uop <= next_uop;
    ex_busy      <= !drain && !directed && (rand_below(4) == 0);
    r = -1;
    if (!directed && (drain || rand_below(2) == 0)) begin
      r = find_reg(1'b1, -1);
    end
    wb_valid <= (r >= 0);
    wb_index <= (r >= 0) ? REG_W'(r) : '0;
  endtask

  initial begin
    seed             = 34436;
    clock            = 1'b0;
    reset            = 1'b1;
    dispatch_uop     = '0;
    ex_busy          = 1'b0;
    wb_valid         = 1'b0;
    wb_index         = '0;
    model_busy       = '0;
    next_tag         = 0;
    dispatched_count = 0;
    issued_count     = 0;
    exp_ready        = 1'b1;
    exp_fire         = 1'b0;
    pick_idx         = -1;
    repeat (4) @(posedge clock);
    reset <= 1'b0;

    // Opening cycles use immediate sources with no stall, so order is kept
    for (int c = 0; c < RANDOM_CYCLES; c++) begin
      check_outputs();
      advance_edge(1'b0, c < DIRECTED_CYCLES);
    end

    waited = 0;
    while (model_q.size() != 0 || model_busy != '0) begin
      if (waited == DRAIN_TIMEOUT) begin
        $display("Timeout: queue or busy table still not empty after drain");
        fail_run();
      end
      check_outputs();
      advance_edge(1'b1, 1'b0);
      waited++;
    end
    check_outputs();

    if (issued_count == dispatched_count) begin
      $display("Regression passed");
      $finish;
    end else begin
      $display("Dispatched %0d micro-ops but issued %0d", dispatched_count, issued_count);
      fail_run();
    end
  end

endmodule

`default_nettype wire

// File: source/issue_queue_mem.sv
//##########################################################
// Memory issue queue
// Eight compacted slots, one load or store issued per cycle
//##########################################################

`timescale 1ns/1ps
`default_nettype none

`include "mem_issue_defines.svh"

module issue_queue_mem (
  input  logic                                            clock,
  input  logic                                            reset,
  input  mem_issue_pkg::micro_op_t [`DISPATCH_WIDTH-1:0]  dispatch_uop,
  input  logic                                            ex_busy,
  input  logic                                            wb_valid,
  input  logic [`PRF_INDEX_SIZE-1:0]                      wb_index,
  output logic                                            dispatch_ready,
  output mem_issue_pkg::micro_op_t                        issue_uop,
  output logic                                            issue_valid
);

  logic [`DISPATCH_WIDTH-1:0]                   dispatch_fire;
  logic                                         issue_fire;
  logic [`IQ_MEM_SIZE-1:0][`PRF_INDEX_SIZE-1:0] rs1_index;
  logic [`IQ_MEM_SIZE-1:0][`PRF_INDEX_SIZE-1:0] rs2_index;
  logic [`IQ_MEM_SIZE-1:0]                      rs1_busy;
  logic [`IQ_MEM_SIZE-1:0]                      rs2_busy;

  iq_slot_if slot_bus [`IQ_MEM_SIZE] ();

  iq_mem_allocator allocator (
    .clock          (clock),
    .reset          (reset),
    .dispatch_uop   (dispatch_uop),
    .issue_fire     (issue_fire),
    .slots          (slot_bus),
    .dispatch_ready (dispatch_ready),
    .dispatch_fire  (dispatch_fire)
  );

  // Slot 0 holds the oldest entry
  for (genvar k = 0; k < `IQ_MEM_SIZE; k++) begin : g_slot
    issue_slot_mem slot (
      .clock     (clock),
      .reset     (reset),
      .rs1_busy  (rs1_busy[k]),
      .rs2_busy  (rs2_busy[k]),
      .slot      (slot_bus[k]),
      .rs1_index (rs1_index[k]),
      .rs2_index (rs2_index[k])
    );
  end

  iq_mem_selector selector (
    .ex_busy     (ex_busy),
    .slots       (slot_bus),
    .issue_uop   (issue_uop),
    .issue_valid (issue_valid),
    .issue_fire  (issue_fire)
  );

  prf_busy_table busy_table (
    .clock         (clock),
    .reset         (reset),
    .dispatch_uop  (dispatch_uop),
    .dispatch_fire (dispatch_fire),
    .wb_valid      (wb_valid),
    .wb_index      (wb_index),
    .rs1_index     (rs1_index),
    .rs2_index     (rs2_index),
    .rs1_busy      (rs1_busy),
    .rs2_busy      (rs2_busy)
  );

endmodule

`default_nettype wire

// File: source/iq_mem_selector.sv
//##########################################################
// Memory issue selector
// Oldest-ready pick, slot clear and compaction shift
//##########################################################

`timescale 1ns/1ps
`default_nettype none

`include "mem_issue_defines.svh"

module iq_mem_selector (
  input  logic                      ex_busy,
  iq_slot_if.select                 slots [`IQ_MEM_SIZE],
  output mem_issue_pkg::micro_op_t  issue_uop,
  output logic                      issue_valid,
  output logic                      issue_fire
);
  import mem_issue_pkg::*;

  localparam int SEL_W = $clog2(`IQ_MEM_SIZE);

  micro_op_t               uops [`IQ_MEM_SIZE+1];
  logic [`IQ_MEM_SIZE-1:0] candidate;
  logic [`IQ_MEM_SIZE-1:0] clear_vec;
  logic [`IQ_MEM_SIZE-1:0] valid_vec;
  logic [SEL_W-1:0]        sel;
  logic                    sel_valid;

  // Stores wait for slot 0 so they never pass an older memory op
  for (genvar k = 0; k < `IQ_MEM_SIZE; k++) begin : g_cand
    assign uops[k]      = slots[k].uop;
    assign valid_vec[k] = slots[k].uop.valid;
    if (k == 0) begin : g_head
      assign candidate[k] = slots[k].ready;
    end else begin : g_body
      assign candidate[k] = slots[k].ready && (slots[k].uop.mem_type == MEM_LD);
    end
  end

  // Empty entry shifted into the top slot
  assign uops[`IQ_MEM_SIZE] = '0;

  always_comb begin
    sel       = '0;
    sel_valid = 1'b0;
    for (int k = `IQ_MEM_SIZE - 1; k >= 0; k--) begin
      if (candidate[k]) begin
        sel       = SEL_W'(k);
        sel_valid = 1'b1;
      end
    end
  end

  assign issue_fire  = sel_valid && !ex_busy;
  assign issue_valid = issue_fire;
  assign issue_uop   = uops[sel];

  for (genvar k = 0; k < `IQ_MEM_SIZE; k++) begin : g_shift
    assign clear_vec[k]     = issue_fire && (int'(sel) == k);
    assign slots[k].clear   = clear_vec[k];
    assign slots[k].uop_new = (issue_fire && int'(sel) <= k) ? uops[k+1] : uops[k];
  end

  // Occupied slots stay packed from slot 0 after every shift and placement
  always_comb begin
    entries_packed: assert final (((valid_vec >> 1) & ~valid_vec) == '0)
      else $error("occupied slots not packed: %b", valid_vec);
  end

endmodule

`default_nettype wire

// File: source/iq_mem_allocator.sv
//##########################################################
// Memory issue queue allocator
// Tracks tail and free slots, places dispatched micro-ops
//##########################################################

`timescale 1ns/1ps
`default_nettype none

`include "mem_issue_defines.svh"

module iq_mem_allocator (
  input  logic                                            clock,
  input  logic                                            reset,
  input  mem_issue_pkg::micro_op_t [`DISPATCH_WIDTH-1:0]  dispatch_uop,
  input  logic                                            issue_fire,
  iq_slot_if.alloc                                        slots [`IQ_MEM_SIZE],
  output logic                                            dispatch_ready,
  output logic [`DISPATCH_WIDTH-1:0]                      dispatch_fire
);

  localparam int CNT_W = $clog2(`IQ_MEM_SIZE) + 1;

  logic [CNT_W-1:0]        tail_reg;
  logic [CNT_W-1:0]        free_count_reg;
  logic [CNT_W-1:0]        in_count;
  logic [CNT_W-1:0]        out_count;
  logic [CNT_W-1:0]        base;
  logic [`IQ_MEM_SIZE-1:0] free_bits;

  // Decided from registered state only
  assign dispatch_ready = free_count_reg >= CNT_W'(`DISPATCH_WIDTH);

  for (genvar i = 0; i < `DISPATCH_WIDTH; i++) begin : g_fire
    assign dispatch_fire[i] = dispatch_ready && dispatch_uop[i].valid;
  end

  always_comb begin
    in_count = '0;
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      in_count = in_count + CNT_W'(dispatch_fire[i]);
    end
  end

  assign out_count = CNT_W'(issue_fire);

  // New entries land at the tail as it stands after compaction
  assign base = tail_reg - out_count;

  for (genvar k = 0; k < `IQ_MEM_SIZE; k++) begin : g_route
    always_comb begin
      slots[k].load   = 1'b0;
      slots[k].uop_in = '0;
      for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
        if (dispatch_fire[i] && (int'(base) + i == k)) begin
          slots[k].load   = 1'b1;
          slots[k].uop_in = dispatch_uop[i];
        end
      end
    end
    assign free_bits[k] = slots[k].free;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      tail_reg       <= '0;
      free_count_reg <= CNT_W'(`IQ_MEM_SIZE);
    end else begin
      tail_reg       <= base + in_count;
      free_count_reg <= free_count_reg - in_count + out_count;
    end
  end

  // An underflow wraps above the queue size, so one bound covers both ends
  free_count_bounded: assert property (
    @(posedge clock) disable iff (reset) free_count_reg <= CNT_W'(`IQ_MEM_SIZE)
  ) else $error("free count out of range: %0d", free_count_reg);

  free_count_matches_slots: assert property (
    @(posedge clock) disable iff (reset)
      int'(free_count_reg) == $countones(free_bits)
  ) else $error("free count %0d disagrees with empty slots", free_count_reg);

endmodule

`default_nettype wire

// File: source/issue_slot_mem.sv
//##########################################################
// Memory issue slot
// Holds one micro-op and reports whether it can issue
//##########################################################

`timescale 1ns/1ps
`default_nettype none

`include "mem_issue_defines.svh"

module issue_slot_mem (
  input  logic                        clock,
  input  logic                        reset,
  input  logic                        rs1_busy,
  input  logic                        rs2_busy,
  iq_slot_if.slot                     slot,
  output logic [`PRF_INDEX_SIZE-1:0]  rs1_index,
  output logic [`PRF_INDEX_SIZE-1:0]  rs2_index
);
  import mem_issue_pkg::*;

  logic rs1_ready;
  logic rs2_ready;

  // An issued entry leaves through uop_new, which brings the next younger one in
  always_ff @(posedge clock) begin
    if (reset) begin
      slot.uop <= '0;
    end else if (slot.load) begin
      slot.uop <= slot.uop_in;
    end else begin
      slot.uop <= slot.uop_new;
    end
  end

  assign rs1_index = (slot.uop.rs1_source == RS_FROM_RF) ? slot.uop.rs1_index : '0;
  assign rs2_index = (slot.uop.rs2_source == RS_FROM_RF) ? slot.uop.rs2_index : '0;

  assign rs1_ready = (slot.uop.rs1_source == RS_FROM_IMM) || !rs1_busy;
  assign rs2_ready = (slot.uop.rs2_source == RS_FROM_IMM) || !rs2_busy;

  assign slot.ready = slot.uop.valid && rs1_ready && rs2_ready;
  assign slot.free  = !slot.uop.valid;

  // Selector must never pick an entry still waiting on the busy table
  clear_only_ready: assert property (
    @(posedge clock) disable iff (reset) slot.clear |-> slot.ready
  ) else $error("slot cleared while not ready");

endmodule

`default_nettype wire

// File: source/prf_busy_table.sv
//##########################################################
// Physical register busy table
// Loads mark rd busy at dispatch, writeback clears it
//##########################################################

`timescale 1ns/1ps
`default_nettype none

`include "mem_issue_defines.svh"

module prf_busy_table (
  input  logic                                              clock,
  input  logic                                              reset,
  input  mem_issue_pkg::micro_op_t [`DISPATCH_WIDTH-1:0]    dispatch_uop,
  input  logic [`DISPATCH_WIDTH-1:0]                        dispatch_fire,
  input  logic                                              wb_valid,
  input  logic [`PRF_INDEX_SIZE-1:0]                        wb_index,
  input  logic [`IQ_MEM_SIZE-1:0][`PRF_INDEX_SIZE-1:0]      rs1_index,
  input  logic [`IQ_MEM_SIZE-1:0][`PRF_INDEX_SIZE-1:0]      rs2_index,
  output logic [`IQ_MEM_SIZE-1:0]                           rs1_busy,
  output logic [`IQ_MEM_SIZE-1:0]                           rs2_busy
);
  import mem_issue_pkg::*;

  localparam int PRF_SIZE = 1 << `PRF_INDEX_SIZE;

  logic [PRF_SIZE-1:0] busy;
  logic [PRF_SIZE-1:0] busy_next;

  // Clear first so a same-cycle load set takes priority
  always_comb begin
    busy_next = busy;
    if (wb_valid) begin
      busy_next[wb_index] = 1'b0;
    end
    for (int i = 0; i < `DISPATCH_WIDTH; i++) begin
      if (dispatch_fire[i] && dispatch_uop[i].mem_type == MEM_LD) begin
        busy_next[dispatch_uop[i].rd_index] = 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
    end else begin
      busy <= busy_next;
    end
  end

  for (genvar k = 0; k < `IQ_MEM_SIZE; k++) begin : g_lookup
    assign rs1_busy[k] = busy[rs1_index[k]];
    assign rs2_busy[k] = busy[rs2_index[k]];
  end

  // Writeback only for a register some load is still producing
  wb_targets_busy: assert property (
    @(posedge clock) disable iff (reset) wb_valid |-> busy[wb_index]
  ) else $error("writeback to idle register %0d", wb_index);

endmodule

`default_nettype wire

// File: source/iq_slot_if.sv
//##########################################################
// Issue slot interface
// Links one queue entry to the allocator and selector
//##########################################################

`timescale 1ns/1ps
`default_nettype none

interface iq_slot_if;
  import mem_issue_pkg::*;

  // Written by the allocator
  logic      load;
  micro_op_t uop_in;

  // Written by the selector
  logic      clear;
  micro_op_t uop_new;

  // Slot state
  micro_op_t uop;
  logic      ready;
  logic      free;

  modport slot (
    input  load,
    input  uop_in,
    input  clear,
    input  uop_new,
    output uop,
    output ready,
    output free
  );

  modport alloc (output load, output uop_in, input free);

  modport select (output clear, output uop_new, input uop, input ready);

endinterface

`default_nettype wire

// File: source/mem_issue_pkg.sv
//##########################################################
// Memory issue package
// Micro-op layout and opcode encodings
//##########################################################

`default_nettype none

`include "mem_issue_defines.svh"

package mem_issue_pkg;

  typedef enum logic [1:0] {
    MEM_LD = 2'd0,
    MEM_ST = 2'd1
  } mem_op_e;

  // Whether a source operand comes from a register
  typedef enum logic {
    RS_FROM_RF  = 1'b0,
    RS_FROM_IMM = 1'b1
  } rs_source_e;

  typedef struct packed {
    logic                         valid;
    logic [`ROB_TAG_SIZE-1:0]     tag;
    mem_op_e                      mem_type;
    rs_source_e                   rs1_source;
    logic [`PRF_INDEX_SIZE-1:0]   rs1_index;
    rs_source_e                   rs2_source;
    logic [`PRF_INDEX_SIZE-1:0]   rs2_index;
    // Loads only
    logic [`PRF_INDEX_SIZE-1:0]   rd_index;
  } micro_op_t;

endpackage

`default_nettype wire

// File: source/mem_issue_defines.svh
//##########################################################
// Memory issue queue sizing
// Queue depth, dispatch width and index widths
//##########################################################

`ifndef MEM_ISSUE_DEFINES_SVH
`define MEM_ISSUE_DEFINES_SVH

// Slots in the memory issue queue
`define IQ_MEM_SIZE 8

// Micro-ops accepted from dispatch per cycle
`define DISPATCH_WIDTH 2

// 64 physical registers
`define PRF_INDEX_SIZE 6

`define ROB_TAG_SIZE 6

`endif
